//--- src.f
common/keypad_pkg.sv
keypad_scan/keypad_scanner.sv
keypad_scan/key_classifier.sv
rtl/multitap_fsm.sv
rtl/letter_fifo_wb.sv
rtl/keypad_text_top.sv
tests/keypad_checker.sv
tests/tb_keypad_text.sv

//--- Bender.yml
package:
  name: keypad_text

sources:
  - common/keypad_pkg.sv
  - keypad_scan/keypad_scanner.sv
  - keypad_scan/key_classifier.sv
  - rtl/multitap_fsm.sv
  - rtl/letter_fifo_wb.sv
  - rtl/keypad_text_top.sv
  - target: test
    files:
      - tests/keypad_checker.sv
      - tests/tb_keypad_text.sv

//--- tests/tb_keypad_text.sv
`timescale 1ns/10ps
`default_nettype none

module tb_keypad_text import keypad_pkg::*; ();

  logic        clk;
  logic        nRst;
  logic [3:0]  read_row;
  logic [3:0]  scan_col;
  logic        preview_valid;
  logic [7:0]  preview_char;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic        wb_adr;
  logic [15:0] wb_dat_w;
  wb_rdata_u   wb_dat_r;
  logic        wb_ack;
  int          value_errors;
  int          other_errors;
  logic [31:0] lfsr_state;
  int          k;
  int          d;
  int          t;
  int          op;

  always #50 clk = ~clk; // 100 ns period

  keypad_text_top keypad_text_top_i (
    .clk(clk), .nRst(nRst), .read_row(read_row), .scan_col(scan_col),
    .preview_valid(preview_valid), .preview_char(preview_char),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
  );

  keypad_checker checker_i (
    .clk(clk), .nRst(nRst), .preview_valid(preview_valid), .preview_char(preview_char),
    .wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r),
    .wb_ack(wb_ack), .value_errors(value_errors), .other_errors(other_errors)
  );

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = (v << 1) | int'(lfsr_state[0]);
    end
  endtask

  // Keypad model drives the row only while its column is scanned
  task automatic press_key(input int r, input int c);
    logic [3:0] row_oh;
    logic [3:0] col_oh;
    logic       found;
    row_oh = 4'b1000 >> r;
    col_oh = 4'b1000 >> c;
    found  = 1'b0;
    for (int i = 0; i < 16 && !found; i++) begin
      @(negedge clk);
      found = (scan_col == {col_oh[2:0], col_oh[3]}); // Column before the key's
    end
    if (!found) begin
      checker_i.report_other("scan_col never reached the key column");
    end else begin
      @(posedge clk);
      read_row <= row_oh; // Lands with scan_col on the key column
      repeat (11) @(posedge clk);
      @(negedge clk);
      checker_i.compare_hex("scan_col", 16'(col_oh), 16'(scan_col)); // Frozen under the key
      @(posedge clk);
      read_row <= '0;
      repeat (12) @(posedge clk); // Idle gap
      @(negedge clk);
      checker_i.note_key(r, c);
      checker_i.check_preview();
    end
  endtask

  task automatic press_digit(input int digit, input int taps);
    repeat (taps) press_key((digit - 1) / 3, (digit - 1) % 3);
  endtask

  // One Wishbone classic cycle held until ack
  task automatic bus_access(input logic we, input logic adr, input logic [15:0] data);
    logic acked;
    acked = 1'b0;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= data;
    for (int i = 0; i < 8 && !acked; i++) begin
      @(posedge clk);
      acked = wb_ack;
    end
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    if (!acked)
      checker_i.report_other("no Wishbone ack within 8 cycles");
  endtask

  initial begin
    clk        = 1'b0;
    nRst       = 1'b0;
    read_row   = '0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = 1'b0;
    wb_dat_w   = '0;
    lfsr_state = 32'h6aeee8bc;
    repeat (16) @(posedge clk);
    checker_i.compare_hex("scan_col", 16'h0, 16'(scan_col)); // No column driven in reset
    checker_i.compare_hex("wb_ack", 16'h0, 16'(wb_ack));
    nRst <= 1'b1;
    repeat (4) @(posedge clk);

    // Idle state after reset
    bus_access(1'b0, WB_ADDR_STATUS, '0);
    bus_access(1'b0, WB_ADDR_LETTER, '0);
    checker_i.check_preview();

    // Single taps then three taps on WXYZ
    press_digit(2, 1);
    press_key(3, 0);
    press_digit(9, 3);
    press_key(3, 0);
    bus_access(1'b0, WB_ADDR_STATUS, '0);
    repeat (2) bus_access(1'b0, WB_ADDR_LETTER, '0);

    // Tap wrap and random sequences
    press_digit(7, 5);
    press_key(3, 0);
    press_digit(8, 4);
    press_key(3, 0);
    for (k = 0; k < 4; k++) begin
      take_bits(3, d);
      take_bits(2, t);
      press_digit(d + 2, t + 1);
      press_key(3, 0);
    end
    bus_access(1'b0, WB_ADDR_STATUS, '0);
    repeat (7) bus_access(1'b0, WB_ADDR_LETTER, '0); // One past empty

    // Clear, ignored keys and a replaced digit
    press_digit(5, 2);
    press_key(3, 2);
    press_key(3, 0);
    bus_access(1'b0, WB_ADDR_STATUS, '0);
    press_digit(6, 1);
    press_key(0, 0);
    press_key(3, 1);
    press_key(0, 3);
    press_key(1, 3);
    press_key(2, 3);
    press_key(3, 3);
    bus_access(1'b0, WB_ADDR_STATUS, '0);
    press_digit(3, 1);
    press_key(3, 0);
    bus_access(1'b0, WB_ADDR_STATUS, '0);
    bus_access(1'b0, WB_ADDR_LETTER, '0);

    // Overflow on ten letters
    for (k = 0; k < 10; k++) begin
      press_digit(2 + k % 8, 1);
      press_key(3, 0);
    end
    bus_access(1'b0, WB_ADDR_STATUS, '0);
    repeat (9) bus_access(1'b0, WB_ADDR_LETTER, '0);
    bus_access(1'b1, WB_ADDR_STATUS, 16'h0010); // Overflow bit set clears it
    bus_access(1'b0, WB_ADDR_STATUS, '0);

    // Mixed pushes and pops
    for (k = 0; k < 12; k++) begin
      take_bits(1, op);
      if (op != 0) begin
        take_bits(3, d);
        take_bits(2, t);
        press_digit(d + 2, t + 1);
        press_key(3, 0);
      end else begin
        bus_access(1'b0, WB_ADDR_LETTER, '0);
      end
      bus_access(1'b0, WB_ADDR_STATUS, '0);
    end

    checker_i.print_counts();
    if (value_errors == 0 && other_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/keypad_checker.sv
`timescale 1ns/10ps
`default_nettype none

module keypad_checker import keypad_pkg::*; (
  input  logic        clk,
  input  logic        nRst,
  input  logic        preview_valid,
  input  logic [7:0]  preview_char,
  input  logic        wb_we,
  input  logic        wb_adr,
  input  logic [15:0] wb_dat_w,
  input  wb_rdata_u   wb_dat_r,
  input  logic        wb_ack,
  output int          value_errors,
  output int          other_errors
);

  logic [7:0] exp_q [$]; // Letters expected in the FIFO, head first
  logic       exp_overflow;
  logic       pend_valid;  // Model of the pending letter
  int         pend_digit;
  int         pend_taps;   // Raw tap count, wrapped only in the reference
  wb_rdata_u  wr_word;

  assign wr_word = wb_dat_w;

  // Phone letters, PQRS and WXYZ shift the later keys by one
  function automatic logic [7:0] multitap_letter(input int digit, input int taps);
    int first;
    int letters;
    first   = 65 + 3 * (digit - 2) + ((digit > 7) ? 1 : 0);
    letters = (digit == 7 || digit == 9) ? 4 : 3;
    multitap_letter = 8'(first + (taps - 1) % letters);
  endfunction

  task automatic compare_hex(input string name, input logic [15:0] exp_v,
                             input logic [15:0] act_v);
    if (exp_v !== act_v) begin
      value_errors++;
      $display("[FAIL] %s expected 0x%0h got 0x%0h at %0t", name, exp_v, act_v, $time);
    end
  endtask

  task automatic report_other(input string what);
    other_errors++;
    $display("Error at %0t: %s", $time, what);
  endtask

  // One finished key press at layout row r, column c
  task automatic note_key(input int r, input int c);
    int digit;
    if (r < 3 && c < 3 && !(r == 0 && c == 0)) begin
      digit = r * 3 + c + 1;
      if (pend_valid && digit == pend_digit) begin
        pend_taps++;
      end else begin
        pend_valid = 1'b1; // New key replaces the pending one
        pend_digit = digit;
        pend_taps  = 1;
      end
    end else if (r == 3 && c == 0 && pend_valid) begin
      if (exp_q.size() < FIFO_DEPTH)
        exp_q.push_back(multitap_letter(pend_digit, pend_taps));
      else
        exp_overflow = 1'b1; // Dropped at a full FIFO
      pend_valid = 1'b0;
    end else if (r == 3 && c == 2) begin
      pend_valid = 1'b0;
    end
  endtask

  task automatic check_preview();
    compare_hex("preview_valid", 16'(pend_valid), 16'(preview_valid));
    if (pend_valid)
      compare_hex("preview_char", 16'(multitap_letter(pend_digit, pend_taps)),
                  16'(preview_char));
  endtask

  task automatic print_counts();
    $display("Checker summary: %0d value errors, %0d other errors", value_errors,
             other_errors);
  endtask

  initial begin
    value_errors = 0;
    other_errors = 0;
    exp_overflow = 1'b0;
    pend_valid   = 1'b0;
    pend_digit   = 0;
    pend_taps    = 0;
  end

  // Bus results, sampled on the edge that ends the ack cycle
  always @(posedge clk) begin
    if (nRst && wb_ack) begin
      if (wb_we) begin
        if (wb_adr == WB_ADDR_STATUS && wr_word.status.overflow)
          exp_overflow = 1'b0;
      end else if (wb_adr == WB_ADDR_LETTER) begin
        if (exp_q.size() > 0) begin
          compare_hex("letter.valid", 16'h1, 16'(wb_dat_r.letter.valid));
          compare_hex("letter.ascii", 16'(exp_q.pop_front()), 16'(wb_dat_r.letter.ascii));
        end else begin
          compare_hex("letter.valid", 16'h0, 16'(wb_dat_r.letter.valid)); // Empty pop
        end
      end else begin
        compare_hex("status.count", 16'(exp_q.size()), 16'(wb_dat_r.status.count));
        compare_hex("status.overflow", 16'(exp_overflow), 16'(wb_dat_r.status.overflow));
        compare_hex("status.preview_valid", 16'(pend_valid),
                    16'(wb_dat_r.status.preview_valid));
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/keypad_text_top.sv
`timescale 1ns/10ps
`default_nettype none

module keypad_text_top import keypad_pkg::*; (
  input  logic        clk,
  input  logic        nRst,
  input  logic [3:0]  read_row,
  output logic [3:0]  scan_col,
  output logic        preview_valid,
  output logic [7:0]  preview_char,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic        wb_adr,
  input  logic [15:0] wb_dat_w,
  output wb_rdata_u   wb_dat_r,
  output logic        wb_ack
);

  logic       key_valid;
  key_code_t  key;
  logic       ev_valid;
  key_event_t ev;
  logic       letter_valid;
  letter_t    letter;

  keypad_scanner keypad_scanner_i (
    .clk       (clk),
    .nRst      (nRst),
    .read_row  (read_row),
    .scan_col  (scan_col),
    .key_valid (key_valid),
    .key       (key)
  );

  key_classifier key_classifier_i (
    .clk       (clk),
    .nRst      (nRst),
    .key_valid (key_valid),
    .key       (key),
    .ev_valid  (ev_valid),
    .ev        (ev)
  );

  multitap_fsm multitap_fsm_i (
    .clk           (clk),
    .nRst          (nRst),
    .ev_valid      (ev_valid),
    .ev            (ev),
    .letter_valid  (letter_valid),
    .letter        (letter),
    .preview_valid (preview_valid),
    .preview_char  (preview_char)
  );

  letter_fifo_wb letter_fifo_wb_i (
    .clk           (clk),
    .nRst          (nRst),
    .letter_valid  (letter_valid),
    .letter        (letter),
    .preview_valid (preview_valid), // Shown in the status word
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_dat_w      (wb_dat_w),
    .wb_dat_r      (wb_dat_r),
    .wb_ack        (wb_ack)
  );

endmodule

`default_nettype wire

//--- rtl/letter_fifo_wb.sv
`timescale 1ns/10ps
`default_nettype none

module letter_fifo_wb import keypad_pkg::*; (
  input  logic        clk,
  input  logic        nRst,
  input  logic        letter_valid,
  input  letter_t     letter,
  input  logic        preview_valid,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic        wb_adr,
  input  logic [15:0] wb_dat_w,
  output wb_rdata_u   wb_dat_r,
  output logic        wb_ack
);

  letter_t            mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr, rd_ptr;
  logic [FIFO_AW:0]   count;
  logic               overflow;
  logic               served; // Ack given and waiting for stb to drop
  logic               req;
  logic               push, pop;
  logic               empty, full;
  wb_rdata_u          wr_word;

  assign empty   = (count == '0);
  assign full    = (count == (FIFO_AW+1)'(FIFO_DEPTH));
  assign wr_word = wb_dat_w; // Same layout as the status word

  // New bus cycle seen this edge
  assign req = wb_cyc & wb_stb & ~wb_ack & ~served;

  assign pop  = req & ~wb_we & (wb_adr == WB_ADDR_LETTER) & ~empty;
  assign push = letter_valid & (~full | pop); // Pop frees a slot in the same cycle

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
      wb_ack   <= 1'b0;
      served   <= 1'b0;
    end else begin
      wb_ack <= req;
      if (wb_ack)
        served <= 1'b1;
      else if (!wb_stb)
        served <= 1'b0;

      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;

      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ; // Both or neither
      endcase

      // Write 1 to the overflow bit clears it and a new drop wins
      if (req && wb_we && wb_adr == WB_ADDR_STATUS && wr_word.status.overflow)
        overflow <= 1'b0;
      if (letter_valid && !push)
        overflow <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= letter;
  end

  // Read word latched with the request
  always_ff @(posedge clk) begin
    if (req && !wb_we) begin
      if (wb_adr == WB_ADDR_LETTER) begin
        wb_dat_r.letter.valid <= ~empty;
        wb_dat_r.letter.pad   <= '0;
        wb_dat_r.letter.ascii <= mem[rd_ptr].ascii;
      end else begin
        wb_dat_r.status.pad           <= '0;
        wb_dat_r.status.preview_valid <= preview_valid;
        wb_dat_r.status.overflow      <= overflow;
        wb_dat_r.status.count         <= count;
      end
    end
  end

  a_count_bound: assert property (
    @(posedge clk) disable iff (!nRst) count <= FIFO_DEPTH
  );

  // Ack only answers a strobe
  a_ack_needs_stb: assert property (
    @(posedge clk) disable iff (!nRst) $rose(wb_ack) |-> $past(wb_stb)
  );

endmodule

`default_nettype wire

//--- rtl/multitap_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module multitap_fsm import keypad_pkg::*; (
  input  logic       clk,
  input  logic       nRst,
  input  logic       ev_valid,
  input  key_event_t ev,
  output logic       letter_valid,
  output letter_t    letter,
  output logic       preview_valid,
  output logic [7:0] preview_char
);

  logic [3:0] cur_digit; // Pending key
  logic [1:0] tap_idx;   // Taps minus one, wrapped
  logic [1:0] tap_next;
  logic [7:0] base;
  logic       same_key;
  logic       is_letter_key;

  // Base letter, blank outside 2 to 9
  assign is_letter_key = (cur_digit >= 4'd2) && (cur_digit <= 4'd9);
  assign base          = is_letter_key ? LETTER_BASE[cur_digit] : 8'h00;
  assign preview_char  = base + {6'd0, tap_idx};

  assign same_key = preview_valid && (cur_digit == ev.digit);

  // Wrap on the key's letter count
  always_comb begin
    if (is_letter_key && ({1'b0, tap_idx} + 3'd1 == TAP_LIMIT[cur_digit]))
      tap_next = 2'd0;
    else
      tap_next = tap_idx + 2'd1;
  end

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      preview_valid <= 1'b0;
      cur_digit     <= 4'd0;
      tap_idx       <= 2'd0;
      letter_valid  <= 1'b0;
    end else begin
      letter_valid <= 1'b0; // Single cycle pulse
      if (ev_valid) begin
        case (ev.cls)
          KEY_LETTER: begin
            if (same_key) begin
              tap_idx <= tap_next; // Next letter on this key
            end else begin
              preview_valid <= 1'b1;
              cur_digit     <= ev.digit;
              tap_idx       <= 2'd0; // New key starts at its first letter
            end
          end
          KEY_SUBMIT: begin
            if (preview_valid) begin
              letter_valid  <= 1'b1;
              preview_valid <= 1'b0;
              tap_idx       <= 2'd0;
            end
          end
          KEY_CLEAR: begin
            preview_valid <= 1'b0; // Drop pending letter
            tap_idx       <= 2'd0;
          end
          default: ; // 1, 0, A to D do nothing
        endcase
      end
    end
  end

  // Letter out is the preview at submit time
  always_ff @(posedge clk) begin
    if (ev_valid && ev.cls == KEY_SUBMIT && preview_valid)
      letter.ascii <= preview_char;
  end

  // Every emitted letter had a visible preview
  a_letter_from_preview: assert property (
    @(posedge clk) disable iff (!nRst) letter_valid |-> $past(preview_valid)
  );

endmodule

`default_nettype wire

//--- keypad_scan/key_classifier.sv
`timescale 1ns/10ps
`default_nettype none

module key_classifier import keypad_pkg::*; (
  input  logic       clk,
  input  logic       nRst,
  input  logic       key_valid,
  input  key_code_t  key,
  output logic       ev_valid,
  output key_event_t ev
);

  logic [1:0] row_idx, col_idx;
  logic [3:0] digit;
  logic       key_ok;
  key_class_e cls;

  // One-hot line to index, bit 3 is line 0
  function automatic logic [1:0] line_index(input logic [3:0] line);
    case (line)
      4'b1000: line_index = 2'd0;
      4'b0100: line_index = 2'd1;
      4'b0010: line_index = 2'd2;
      default: line_index = 2'd3;
    endcase
  endfunction

  assign key_ok  = $onehot(key.row) & $onehot(key.col); // Ghosted or lost presses fail here
  assign row_idx = line_index(key.row);
  assign col_idx = line_index(key.col);

  // Phone layout lookup
  always_comb begin
    case ({row_idx, col_idx})
      4'h0: digit = 4'd1;
      4'h1: digit = 4'd2;
      4'h2: digit = 4'd3;
      4'h3: digit = 4'd10; // A
      4'h4: digit = 4'd4;
      4'h5: digit = 4'd5;
      4'h6: digit = 4'd6;
      4'h7: digit = 4'd11; // B
      4'h8: digit = 4'd7;
      4'h9: digit = 4'd8;
      4'ha: digit = 4'd9;
      4'hb: digit = 4'd12; // C
      4'hc: digit = 4'd14; // *
      4'hd: digit = 4'd0;
      4'he: digit = 4'd15; // #
      default: digit = 4'd13; // D
    endcase
  end

  always_comb begin
    if (key == SUBMIT_CODE)
      cls = KEY_SUBMIT;
    else if (key == CLEAR_CODE)
      cls = KEY_CLEAR;
    else if (digit >= 4'd2 && digit <= 4'd9)
      cls = KEY_LETTER;
    else
      cls = KEY_IGNORE;
  end

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst)
      ev_valid <= 1'b0;
    else
      ev_valid <= key_valid & key_ok;
  end

  always_ff @(posedge clk) begin
    if (key_valid) begin
      ev.cls   <= cls;
      ev.digit <= digit;
    end
  end

endmodule

`default_nettype wire

//--- keypad_scan/keypad_scanner.sv
`timescale 1ns/10ps
`default_nettype none

module keypad_scanner import keypad_pkg::*; (
  input  logic       clk,
  input  logic       nRst,
  input  logic [3:0] read_row,
  output logic [3:0] scan_col,
  output logic       key_valid,
  output key_code_t  key
);

  logic [3:0] row_q0, row_q1; // Two-flop synchronizer
  logic       any_q;          // Previous synchronized any-row
  logic [3:0] scan_col_next;
  logic       any_row;

  assign any_row = |row_q1;

  // Column rotation, frozen while a row is driven
  always_comb begin
    if (|read_row) begin
      scan_col_next = scan_col; // Hold the column under the pressed key
    end else begin
      case (scan_col)
        4'b1000: scan_col_next = 4'b0100;
        4'b0100: scan_col_next = 4'b0010;
        4'b0010: scan_col_next = 4'b0001;
        4'b0001: scan_col_next = 4'b1000;
        default: scan_col_next = 4'b1000; // Start from column 0 after reset
      endcase
    end
  end

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      scan_col  <= 4'd0;
      row_q0    <= 4'd0;
      row_q1    <= 4'd0;
      any_q     <= 1'b0;
      key_valid <= 1'b0;
    end else begin
      scan_col  <= scan_col_next;
      row_q0    <= read_row;
      row_q1    <= row_q0;
      any_q     <= any_row;
      key_valid <= any_row & ~any_q; // One pulse per press
    end
  end

  // Key code captured with the press edge
  always_ff @(posedge clk) begin
    if (any_row && !any_q) begin
      key.row <= row_q1;
      key.col <= scan_col; // Still frozen by the raw row
    end
  end

  // Column drive stays idle or one-hot at all times
  a_scan_col_onehot: assert property (
    @(posedge clk) disable iff (!nRst) $onehot0(scan_col)
  );

endmodule

`default_nettype wire

//--- common/keypad_pkg.sv
`default_nettype none

package keypad_pkg;

  // Raw key as seen by the scanner, both halves one-hot
  // Row 0 sits on bit 3, column 0 on bit 3
  typedef struct packed {
    logic [3:0] row;
    logic [3:0] col;
  } key_code_t;

  typedef enum logic [1:0] {
    KEY_LETTER = 2'd0, // Digits 2 to 9
    KEY_SUBMIT = 2'd1, // *
    KEY_CLEAR  = 2'd2, // #
    KEY_IGNORE = 2'd3  // 1, 0, A to D
  } key_class_e;

  typedef struct packed {
    key_class_e cls;
    logic [3:0] digit; // Layout digit, * is 14 and # is 15
  } key_event_t;

  typedef struct packed {
    logic [7:0] ascii;
  } letter_t;

  // Read word at WB_ADDR_STATUS
  typedef struct packed {
    logic [9:0] pad;
    logic       preview_valid;
    logic       overflow; // Sticky, write 1 to clear
    logic [3:0] count;
  } wb_status_t;

  // Read word at WB_ADDR_LETTER
  typedef struct packed {
    logic       valid; // Low when FIFO was empty
    logic [6:0] pad;
    logic [7:0] ascii;
  } wb_letter_t;

  typedef union packed {
    wb_status_t status;
    wb_letter_t letter;
  } wb_rdata_u;

  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_AW    = 3;

  localparam logic WB_ADDR_STATUS = 1'b0;
  localparam logic WB_ADDR_LETTER = 1'b1;

  localparam key_code_t SUBMIT_CODE = '{row: 4'b0001, col: 4'b1000}; // Row 3, column 0
  localparam key_code_t CLEAR_CODE  = '{row: 4'b0001, col: 4'b0010}; // Row 3, column 2

  // First letter per digit
  localparam logic [9:2][7:0] LETTER_BASE = {
    8'h57, 8'h54, 8'h50, 8'h4d, // W T P M
    8'h4a, 8'h47, 8'h44, 8'h41  // J G D A
  };

  // Letters per key, PQRS and WXYZ have four
  localparam logic [9:2][2:0] TAP_LIMIT = {
    3'd4, 3'd3, 3'd4, 3'd3,
    3'd3, 3'd3, 3'd3, 3'd3
  };

endpackage

`default_nettype wire
